/* design/sdram_pkg.sv */
/*
 * SDR SDRAM pin protocol: command codes on {ras, cas, we}, pin widths and
 * load-mode field positions. Deselect (cs high) is decoded as cmd_idle.
 */
package sdram_pkg;

    localparam int ADDR_W = 13;
    localparam int BA_W   = 2;
    localparam int DQ_W   = 16;

    // load-mode address fields, 3 bits each
    localparam int MR_CL_LSB = 4;   // cas latency in cycles
    localparam int MR_BL_LSB = 0;   // log2 of burst length

    // {ras, cas, we}, all active low
    typedef enum logic [2:0] {
        cmd_idle      = 3'b111,
        cmd_active    = 3'b011,
        cmd_read      = 3'b101,
        cmd_write     = 3'b100,
        cmd_load_mode = 3'b000
    } sdram_cmd_e;

endpackage

/* design/host_pkg.sv */
/*
 * Host side definitions: operation code and identifiers of the two ports.
 */
package host_pkg;

    localparam int N_PORTS = 2;

    typedef logic [$clog2(N_PORTS)-1:0] port_id_t;

    localparam port_id_t PORT_0 = port_id_t'(0);
    localparam port_id_t PORT_1 = port_id_t'(1);

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } host_op_e;

endpackage

/* design/sdram_req_if.sv */
/*
 * One burst request from the arbiter to the controller. req is a level held
 * with stable fields until the single-cycle done; rdata is valid with done.
 */
`timescale 1ns/1ps

interface sdram_req_if #(
    parameter int BURST_LEN = 2,
    parameter int ROW_W     = 4,
    parameter int COL_W     = 4
);
    logic                                  req;
    host_pkg::host_op_e                    op;
    logic [sdram_pkg::BA_W-1:0]            bank;
    logic [ROW_W-1:0]                      row;
    logic [COL_W-1:0]                      col;
    logic [1:0]                            be;     // bit set = byte written
    logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  wdata;  // beat 0 in the low word
    logic                                  done;
    logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  rdata;

    modport arb  (output req, op, bank, row, col, be, wdata, input done, rdata);
    modport ctrl (input req, op, bank, row, col, be, wdata, output done, rdata);

endinterface

/* design/req_arbiter.sv */
/*
 * Round-robin arbiter for two host ports. A winner is latched only while the
 * request bus is idle and is held until done; port 0 wins the first tie.
 */
`timescale 1ns/1ps

module req_arbiter #(
    parameter int BURST_LEN = 2,
    parameter int ROW_W     = 4,
    parameter int COL_W     = 4
) (
    input  logic                                  clk,
    input  logic                                  cke,
    input  logic                                  p0_req,
    input  host_pkg::host_op_e                    p0_op,
    input  logic [sdram_pkg::BA_W-1:0]            p0_bank,
    input  logic [ROW_W-1:0]                      p0_row,
    input  logic [COL_W-1:0]                      p0_col,
    input  logic [1:0]                            p0_be,
    input  logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  p0_wdata,
    input  logic                                  p1_req,
    input  host_pkg::host_op_e                    p1_op,
    input  logic [sdram_pkg::BA_W-1:0]            p1_bank,
    input  logic [ROW_W-1:0]                      p1_row,
    input  logic [COL_W-1:0]                      p1_col,
    input  logic [1:0]                            p1_be,
    input  logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  p1_wdata,
    output logic                                  p0_done,
    output logic                                  p1_done,
    output logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  p0_rdata,
    output logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  p1_rdata,
    sdram_req_if.arb                              bus
);
    logic                busy;
    host_pkg::port_id_t  gnt;
    host_pkg::port_id_t  last_gnt;
    host_pkg::port_id_t  winner;

    always_comb begin
        if (p0_req && p1_req) begin
            winner = (last_gnt == host_pkg::PORT_0) ? host_pkg::PORT_1 : host_pkg::PORT_0;
        end else if (p1_req) begin
            winner = host_pkg::PORT_1;
        end else begin
            winner = host_pkg::PORT_0;
        end
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            busy     <= 1'b0;
            gnt      <= host_pkg::PORT_0;
            last_gnt <= host_pkg::PORT_1;   // so port 0 takes the first tie
        end else if (!busy && (p0_req || p1_req)) begin
            busy     <= 1'b1;
            gnt      <= winner;
            last_gnt <= winner;
        end else if (busy && bus.done) begin
            busy <= 1'b0;
        end
    end

    assign bus.req   = busy;
    assign bus.op    = (gnt == host_pkg::PORT_1) ? p1_op    : p0_op;
    assign bus.bank  = (gnt == host_pkg::PORT_1) ? p1_bank  : p0_bank;
    assign bus.row   = (gnt == host_pkg::PORT_1) ? p1_row   : p0_row;
    assign bus.col   = (gnt == host_pkg::PORT_1) ? p1_col   : p0_col;
    assign bus.be    = (gnt == host_pkg::PORT_1) ? p1_be    : p0_be;
    assign bus.wdata = (gnt == host_pkg::PORT_1) ? p1_wdata : p0_wdata;

    assign p0_done  = bus.done && (gnt == host_pkg::PORT_0);
    assign p1_done  = bus.done && (gnt == host_pkg::PORT_1);
    assign p0_rdata = (gnt == host_pkg::PORT_0) ? bus.rdata : '0;
    assign p1_rdata = (gnt == host_pkg::PORT_1) ? bus.rdata : '0;

endmodule

/* design/sdram_ctrl.sv */
/*
 * SDRAM command controller: one load-mode after reset, then activate plus
 * read or write per request. No refresh or precharge. All pins are
 * registered, so they show the state of the previous cycle. CAS_LAT >= 1.
 */
`timescale 1ns/1ps

module sdram_ctrl #(
    parameter int CAS_LAT   = 2,
    parameter int BURST_LEN = 2,
    parameter int ROW_W     = 4,
    parameter int COL_W     = 4
) (
    input  logic                          clk,
    input  logic                          cke,
    sdram_req_if.ctrl                     bus,
    output logic                          cs,
    output logic                          ras,
    output logic                          cas,
    output logic                          we,
    output logic [sdram_pkg::ADDR_W-1:0]  a,
    output logic [sdram_pkg::BA_W-1:0]    ba,
    output logic [1:0]                    dqm,
    inout  wire  [sdram_pkg::DQ_W-1:0]    dq
);
    localparam int CNT_MAX = (CAS_LAT > BURST_LEN) ? CAS_LAT : BURST_LEN;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam logic [sdram_pkg::ADDR_W-1:0] MODE_WORD = sdram_pkg::ADDR_W'(
        (CAS_LAT << sdram_pkg::MR_CL_LSB) | ($clog2(BURST_LEN) << sdram_pkg::MR_BL_LSB));

    typedef enum logic [2:0] {
        st_init, st_idle, st_act, st_rw, st_wbeat, st_rwait, st_rbeat, st_fin
    } ctrl_state_e;

    ctrl_state_e                         state, state_n;
    logic [CNT_W-1:0]                    cnt, cnt_n;
    sdram_pkg::sdram_cmd_e               cmd_r, cmd_n;
    logic [sdram_pkg::ADDR_W-1:0]        a_n;
    logic [1:0]                          dqm_n;
    logic                                wr_en_n;
    logic                                dq_oe;
    logic [CNT_W-1:0]                    beat_idx;
    logic [sdram_pkg::DQ_W-1:0]          dq_out;
    logic [BURST_LEN*sdram_pkg::DQ_W-1:0] rdata_r;

    always_comb begin
        state_n  = state;
        cnt_n    = cnt;
        cmd_n    = sdram_pkg::cmd_idle;
        a_n      = '0;
        dqm_n    = 2'b11;
        wr_en_n  = 1'b0;
        beat_idx = (state == st_wbeat) ? cnt : '0;
        case (state)
            st_init: begin
                cmd_n   = sdram_pkg::cmd_load_mode;
                a_n     = MODE_WORD;
                state_n = st_idle;
            end
            st_idle: if (bus.req) state_n = st_act;
            st_act: begin
                cmd_n   = sdram_pkg::cmd_active;
                a_n     = sdram_pkg::ADDR_W'(bus.row);
                state_n = st_rw;
            end
            st_rw: begin
                a_n = sdram_pkg::ADDR_W'(bus.col);
                if (bus.op == host_pkg::op_write) begin
                    cmd_n   = sdram_pkg::cmd_write;
                    dqm_n   = ~bus.be;
                    wr_en_n = 1'b1;   // beat 0 goes with the command
                    cnt_n   = CNT_W'(1);
                    state_n = (BURST_LEN > 1) ? st_wbeat : st_fin;
                end else begin
                    cmd_n   = sdram_pkg::cmd_read;
                    dqm_n   = 2'b00;
                    cnt_n   = '0;
                    state_n = st_rwait;
                end
            end
            st_wbeat: begin
                dqm_n   = ~bus.be;
                wr_en_n = 1'b1;
                if (cnt == CNT_W'(BURST_LEN - 1)) state_n = st_fin;
                else cnt_n = cnt + 1'b1;
            end
            st_rwait: begin
                if (cnt == CNT_W'(CAS_LAT - 1)) begin
                    cnt_n   = '0;
                    state_n = st_rbeat;
                end else begin
                    cnt_n = cnt + 1'b1;
                end
            end
            st_rbeat: begin
                if (cnt == CNT_W'(BURST_LEN - 1)) state_n = st_fin;
                else cnt_n = cnt + 1'b1;
            end
            st_fin: state_n = st_idle;
            default: state_n = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state <= st_init;
            cnt   <= '0;
            cmd_r <= sdram_pkg::cmd_idle;
            cs    <= 1'b1;   // deselected
            dqm   <= 2'b11;
            dq_oe <= 1'b0;
        end else begin
            state <= state_n;
            cnt   <= cnt_n;
            cmd_r <= cmd_n;
            cs    <= (cmd_n == sdram_pkg::cmd_idle);
            dqm   <= dqm_n;
            dq_oe <= wr_en_n;
        end
    end

    always_ff @(posedge clk) begin
        a      <= a_n;
        ba     <= bus.bank;
        dq_out <= bus.wdata[beat_idx*sdram_pkg::DQ_W +: sdram_pkg::DQ_W];
        if (state == st_rbeat) begin
            rdata_r[cnt*sdram_pkg::DQ_W +: sdram_pkg::DQ_W] <= dq;
        end
    end

    assign {ras, cas, we} = cmd_r;
    assign dq             = dq_oe ? dq_out : 'z;
    assign bus.done       = (state == st_fin);
    assign bus.rdata      = rdata_r;

endmodule

/* design/sdram_model.sv */
/*
 * Behavioral SDR SDRAM with 4 banks of 2**ROW_W rows by 2**COL_W columns.
 * Bursts wrap within the row. CAS latency and burst length come from the
 * mode register; CL of 0 is not supported. No refresh or precharge.
 */
`timescale 1ns/1ps

module sdram_model #(
    parameter int ROW_W = 4,
    parameter int COL_W = 4
) (
    input  logic                          clk,
    input  logic                          cke,
    input  logic                          cs,
    input  logic                          ras,
    input  logic                          cas,
    input  logic                          we,
    input  logic [sdram_pkg::ADDR_W-1:0]  a,
    input  logic [sdram_pkg::BA_W-1:0]    ba,
    input  logic [1:0]                    dqm,
    inout  wire  [sdram_pkg::DQ_W-1:0]    dq
);
    localparam int IDX_W = sdram_pkg::BA_W + ROW_W + COL_W;

    logic [sdram_pkg::DQ_W-1:0]  mem [2**IDX_W];
    logic [ROW_W-1:0]            row_open [2**sdram_pkg::BA_W];
    sdram_pkg::sdram_cmd_e       cmd;
    logic [2:0]                  cl_r;
    logic [2:0]                  bl_log;
    logic [4:0]                  bl;
    logic [3:0]                  w_left;
    logic [sdram_pkg::BA_W-1:0]  w_bank, rd_bank;
    logic [COL_W-1:0]            w_col, rd_col;
    logic [IDX_W-1:0]            wr_idx, rd_idx;
    logic                        wr_go;
    logic                        rd_busy, rd_drive;
    logic [4:0]                  rd_tick, rd_beat;
    logic [1:0]                  rd_mask;
    logic [sdram_pkg::DQ_W-1:0]  rd_word;

    assign cmd = cs ? sdram_pkg::cmd_idle : sdram_pkg::sdram_cmd_e'({ras, cas, we});
    assign bl  = 5'd1 << bl_log;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cl_r    <= 3'd2;
            bl_log  <= 3'd0;
            w_left  <= '0;
            rd_busy <= 1'b0;
            rd_tick <= '0;
        end else begin
            if (cmd == sdram_pkg::cmd_load_mode) begin
                cl_r   <= a[sdram_pkg::MR_CL_LSB +: 3];
                bl_log <= a[sdram_pkg::MR_BL_LSB +: 3];
            end
            if (cmd == sdram_pkg::cmd_write) w_left <= 4'(bl - 5'd1);
            else if (w_left != '0) w_left <= w_left - 1'b1;
            if (cmd == sdram_pkg::cmd_read) begin
                rd_busy <= 1'b1;
                rd_tick <= '0;
            end else if (rd_busy) begin
                if (rd_tick == {2'b0, cl_r} + bl - 5'd2) rd_busy <= 1'b0;   // last beat out
                else rd_tick <= rd_tick + 1'b1;
            end
        end
    end

    // open rows, burst pointers and read mask
    always_ff @(posedge clk) begin
        if (cmd == sdram_pkg::cmd_active) row_open[ba] <= a[ROW_W-1:0];
        if (cmd == sdram_pkg::cmd_write) begin
            w_bank <= ba;
            w_col  <= a[COL_W-1:0] + 1'b1;
        end else if (w_left != '0) begin
            w_col <= w_col + 1'b1;
        end
        if (cmd == sdram_pkg::cmd_read) begin
            rd_bank <= ba;
            rd_col  <= a[COL_W-1:0];
            rd_mask <= dqm;
        end
    end

    assign wr_go  = (cmd == sdram_pkg::cmd_write) || (w_left != '0);
    assign wr_idx = (cmd == sdram_pkg::cmd_write) ? {ba, row_open[ba], a[COL_W-1:0]}
                                                  : {w_bank, row_open[w_bank], w_col};

    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int b = 0; b < 2; b++) begin
                if (!dqm[b]) mem[wr_idx][b*8 +: 8] <= dq[b*8 +: 8];
            end
        end
    end

    assign rd_beat  = rd_tick - ({2'b0, cl_r} - 5'd1);
    assign rd_drive = rd_busy && (rd_tick >= {2'b0, cl_r} - 5'd1);
    assign rd_idx   = {rd_bank, row_open[rd_bank], rd_col + COL_W'(rd_beat)};
    assign rd_word  = mem[rd_idx];

    assign dq[7:0]  = (rd_drive && !rd_mask[0]) ? rd_word[7:0]  : 8'bz;
    assign dq[15:8] = (rd_drive && !rd_mask[1]) ? rd_word[15:8] : 8'bz;

endmodule

/* design/sdram_subsys_top.sv */
/*
 * Two host ports sharing one SDRAM. A host holds req with stable fields until
 * its own done; latency depends on arbitration. rdata is valid with done.
 */
`timescale 1ns/1ps

module sdram_subsys_top #(
    parameter int CAS_LAT   = 2,
    parameter int BURST_LEN = 2,
    parameter int ROW_W     = 4,
    parameter int COL_W     = 4
) (
    input  logic                                  clk,
    input  logic                                  cke,
    input  logic                                  p0_req,
    input  host_pkg::host_op_e                    p0_op,
    input  logic [sdram_pkg::BA_W-1:0]            p0_bank,
    input  logic [ROW_W-1:0]                      p0_row,
    input  logic [COL_W-1:0]                      p0_col,
    input  logic [1:0]                            p0_be,
    input  logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  p0_wdata,
    output logic                                  p0_done,
    output logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  p0_rdata,
    input  logic                                  p1_req,
    input  host_pkg::host_op_e                    p1_op,
    input  logic [sdram_pkg::BA_W-1:0]            p1_bank,
    input  logic [ROW_W-1:0]                      p1_row,
    input  logic [COL_W-1:0]                      p1_col,
    input  logic [1:0]                            p1_be,
    input  logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  p1_wdata,
    output logic                                  p1_done,
    output logic [BURST_LEN*sdram_pkg::DQ_W-1:0]  p1_rdata
);
    logic                          cs, ras, cas, we;
    logic [sdram_pkg::ADDR_W-1:0]  a;
    logic [sdram_pkg::BA_W-1:0]    ba;
    logic [1:0]                    dqm;
    wire  [sdram_pkg::DQ_W-1:0]    dq;   // shared data bus

    sdram_req_if #(.BURST_LEN(BURST_LEN), .ROW_W(ROW_W), .COL_W(COL_W)) req_bus ();

    req_arbiter #(.BURST_LEN(BURST_LEN), .ROW_W(ROW_W), .COL_W(COL_W)) u_arb (
        .clk(clk), .cke(cke),
        .p0_req(p0_req), .p0_op(p0_op), .p0_bank(p0_bank), .p0_row(p0_row),
        .p0_col(p0_col), .p0_be(p0_be), .p0_wdata(p0_wdata),
        .p1_req(p1_req), .p1_op(p1_op), .p1_bank(p1_bank), .p1_row(p1_row),
        .p1_col(p1_col), .p1_be(p1_be), .p1_wdata(p1_wdata),
        .p0_done(p0_done), .p1_done(p1_done),
        .p0_rdata(p0_rdata), .p1_rdata(p1_rdata),
        .bus(req_bus.arb)
    );

    sdram_ctrl #(.CAS_LAT(CAS_LAT), .BURST_LEN(BURST_LEN), .ROW_W(ROW_W), .COL_W(COL_W)) u_ctrl (
        .clk(clk), .cke(cke), .bus(req_bus.ctrl),
        .cs(cs), .ras(ras), .cas(cas), .we(we),
        .a(a), .ba(ba), .dqm(dqm), .dq(dq)
    );

    sdram_model #(.ROW_W(ROW_W), .COL_W(COL_W)) u_sdram (
        .clk(clk), .cke(cke),
        .cs(cs), .ras(ras), .cas(cas), .we(we),
        .a(a), .ba(ba), .dqm(dqm), .dq(dq)
    );

endmodule

/* tests/sdram_subsys_asserts.sv */
/*
 * Host port and chip select rules, bound into sdram_subsys_top.
 * Sampled on the rising clock; done rules are off while cke is low.
 */
`timescale 1ns/1ps

module sdram_subsys_asserts (
    input logic clk,
    input logic cke,
    input logic cs,
    input logic p0_req,
    input logic p1_req,
    input logic p0_done,
    input logic p1_done
);
    int unsigned fail_cnt = 0;

    a_done_excl: assert property (@(posedge clk) disable iff (!cke) !(p0_done && p1_done))
        else begin
            $error("p0_done and p1_done are high in the same cycle");
            fail_cnt++;
        end

    a_p0_pulse: assert property (@(posedge clk) disable iff (!cke) p0_done |=> !p0_done)
        else begin
            $error("p0_done stays high for more than one cycle");
            fail_cnt++;
        end

    a_p1_pulse: assert property (@(posedge clk) disable iff (!cke) p1_done |=> !p1_done)
        else begin
            $error("p1_done stays high for more than one cycle");
            fail_cnt++;
        end

    a_p0_req: assert property (@(posedge clk) disable iff (!cke) p0_done |-> p0_req)
        else begin
            $error("p0_done without p0_req");
            fail_cnt++;
        end

    a_p1_req: assert property (@(posedge clk) disable iff (!cke) p1_done |-> p1_req)
        else begin
            $error("p1_done without p1_req");
            fail_cnt++;
        end

    // chip stays deselected in reset
    a_cs_reset: assert property (@(posedge clk) !cke |-> cs)
        else begin
            $error("cs is low while cke is low");
            fail_cnt++;
        end

endmodule

bind sdram_subsys_top sdram_subsys_asserts u_asserts (
    .clk(clk), .cke(cke), .cs(cs),
    .p0_req(p0_req), .p1_req(p1_req),
    .p0_done(p0_done), .p1_done(p1_done)
);

/* tests/tb_sdram_subsys.sv */
/*
 * Testbench for sdram_subsys_top. Bursts are checked against a byte-wise
 * reference memory; reads only target locations written earlier in the run.
 */
`timescale 1ns/1ps

module tb_sdram_subsys;
    localparam int CAS_LAT   = 2;
    localparam int BURST_LEN = 2;
    localparam int ROW_W     = 4;
    localparam int COL_W     = 4;
    localparam int BA_W      = sdram_pkg::BA_W;
    localparam int DQ_W      = sdram_pkg::DQ_W;
    localparam int DW        = BURST_LEN * DQ_W;
    localparam int TIMEOUT   = 40;   // cycles per wait

    logic                clk;
    logic                cke;
    logic [1:0]          req_v;
    wire  [1:0]          done_v;
    host_pkg::host_op_e  op_v [2];
    logic [BA_W-1:0]     bank_v [2];
    logic [ROW_W-1:0]    row_v [2];
    logic [COL_W-1:0]    col_v [2];
    logic [1:0]          be_v [2];
    logic [DW-1:0]       wdata_v [2];
    wire  [DW-1:0]       rdata_v [2];
    logic [DW-1:0]       got_rdata [2];
    logic [DQ_W-1:0]     ref_mem [2**(BA_W+ROW_W+COL_W)];
    int                  done_order [$];
    int                  last_served, test_err, n_pass, n_fail;
    string               test_name;
    logic                ok;

    sdram_subsys_top #(
        .CAS_LAT(CAS_LAT), .BURST_LEN(BURST_LEN), .ROW_W(ROW_W), .COL_W(COL_W)
    ) i_dut (
        .clk(clk), .cke(cke),
        .p0_req(req_v[0]), .p0_op(op_v[0]), .p0_bank(bank_v[0]), .p0_row(row_v[0]),
        .p0_col(col_v[0]), .p0_be(be_v[0]), .p0_wdata(wdata_v[0]),
        .p0_done(done_v[0]), .p0_rdata(rdata_v[0]),
        .p1_req(req_v[1]), .p1_op(op_v[1]), .p1_bank(bank_v[1]), .p1_row(row_v[1]),
        .p1_col(col_v[1]), .p1_be(be_v[1]), .p1_wdata(wdata_v[1]),
        .p1_done(done_v[1]), .p1_rdata(rdata_v[1])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [DW-1:0] exp,
                               input logic [DW-1:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = 0;
    endtask

    task automatic finish_test();
        if (test_err == 0) begin
            n_pass++;
            $display("test %s: pass", test_name);
        end else begin
            n_fail++;
            $display("test %s: fail, %0d errors", test_name, test_err);
        end
    endtask

    task automatic set_fields(input int p, input host_pkg::host_op_e op,
                              input logic [BA_W-1:0] bank, input logic [ROW_W-1:0] row,
                              input logic [COL_W-1:0] col, input logic [1:0] be,
                              input logic [DW-1:0] data);
        op_v[p]    = op;
        bank_v[p]  = bank;
        row_v[p]   = row;
        col_v[p]   = col;
        be_v[p]    = be;
        wdata_v[p] = data;
    endtask

    function automatic logic [DW-1:0] rand_burst();
        logic [DW-1:0] d;
        for (int i = 0; i < BURST_LEN; i++) d[i*DQ_W +: DQ_W] = DQ_W'($urandom());
        return d;
    endfunction

    // req held through the done cycle, dropped on the next falling edge
    task automatic serve_ports(input logic [1:0] mask);
        logic [1:0] seen;
        logic [1:0] drop;
        int         cycles;
        seen   = 2'b00;
        drop   = 2'b00;
        cycles = 0;
        @(negedge clk);
        req_v = mask;
        while (seen != mask && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            req_v = req_v & ~drop;
            drop  = 2'b00;
            for (int p = 0; p < 2; p++) begin
                if (mask[p] && !seen[p] && done_v[p]) begin
                    seen[p]      = 1'b1;
                    drop[p]      = 1'b1;
                    got_rdata[p] = rdata_v[p];
                    last_served  = p;
                    done_order.push_back(p);
                end
            end
        end
        @(negedge clk);
        req_v = 2'b00;
        ok    = (seen == mask);
        if (!ok) begin
            $display("%s: no done within %0d cycles on ports %b", test_name, TIMEOUT,
                     mask & ~seen);
            test_err++;
        end
    endtask

    function automatic void record_write(input int p);
        logic [COL_W-1:0] c;
        for (int i = 0; i < BURST_LEN; i++) begin
            c = col_v[p] + COL_W'(i);   // burst wraps in the row
            for (int b = 0; b < 2; b++) begin
                if (be_v[p][b]) begin
                    ref_mem[{bank_v[p], row_v[p], c}][b*8 +: 8] = wdata_v[p][i*DQ_W + b*8 +: 8];
                end
            end
        end
    endfunction

    task automatic check_read(input int p, input string what);
        logic [DW-1:0]    exp;
        logic [COL_W-1:0] c;
        for (int i = 0; i < BURST_LEN; i++) begin
            c = col_v[p] + COL_W'(i);
            exp[i*DQ_W +: DQ_W] = ref_mem[{bank_v[p], row_v[p], c}];
        end
        check_value(what, exp, got_rdata[p]);
    endtask

    task automatic write_burst(input int p, input logic [BA_W-1:0] bank,
                               input logic [ROW_W-1:0] row, input logic [COL_W-1:0] col,
                               input logic [1:0] be, input logic [DW-1:0] data);
        set_fields(p, host_pkg::op_write, bank, row, col, be, data);
        serve_ports(2'(1 << p));
        if (ok) record_write(p);
    endtask

    task automatic read_burst(input int p, input logic [BA_W-1:0] bank,
                              input logic [ROW_W-1:0] row, input logic [COL_W-1:0] col,
                              input string what);
        set_fields(p, host_pkg::op_read, bank, row, col, 2'b11, '0);
        serve_ports(2'(1 << p));
        if (ok) check_read(p, what);
    endtask

    // the port not served last wins a tie
    task automatic serve_tie(input string what);
        int first_idx;
        int exp_first;
        exp_first = 1 - last_served;
        first_idx = done_order.size();
        serve_ports(2'b11);
        if (ok) check_value({what, " first grant"}, DW'(exp_first), DW'(done_order[first_idx]));
    endtask

    initial begin
        int unsigned asrt_fail;
        void'($urandom(71264));
        cke   = 1'b1;
        req_v = 2'b00;
        for (int p = 0; p < 2; p++) set_fields(p, host_pkg::op_read, '0, '0, '0, 2'b11, '0);
        last_served = 1;
        n_pass      = 0;
        n_fail      = 0;
        #1 cke = 1'b0;   // falling cke resets before the first edge

        start_test("reset_state");
        repeat (4) begin
            @(negedge clk);
            check_value("done during reset", '0, DW'(done_v));
        end
        cke = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_value("done while idle", '0, DW'(done_v));
        end
        finish_test();

        start_test("write_read");
        write_burst(0, 2'd0, 4'd3, 4'd4, 2'b11, rand_burst());
        read_burst(0, 2'd0, 4'd3, 4'd4, "read burst");
        finish_test();

        start_test("byte_mask");
        write_burst(0, 2'd2, 4'd5, 4'd8, 2'b11, rand_burst());
        write_burst(0, 2'd2, 4'd5, 4'd8, 2'b01, rand_burst());   // low bytes only
        read_burst(0, 2'd2, 4'd5, 4'd8, "masked burst");
        finish_test();

        start_test("open_row_per_bank");
        write_burst(0, 2'd1, 4'd7, 4'd0, 2'b11, rand_burst());
        write_burst(0, 2'd3, 4'd9, 4'd2, 2'b11, rand_burst());
        read_burst(0, 2'd1, 4'd7, 4'd0, "bank 1 burst");
        read_burst(0, 2'd3, 4'd9, 4'd2, "bank 3 burst");
        finish_test();

        start_test("arbitration");
        for (int r = 0; r < 3; r++) begin
            // lone access picks which port must win the next tie
            write_burst(r % 2, 2'd3, ROW_W'(r), 4'd12, 2'b11, rand_burst());
            set_fields(0, host_pkg::op_write, 2'd0, ROW_W'(10 + r), 4'd0, 2'b11, rand_burst());
            set_fields(1, host_pkg::op_write, 2'd1, ROW_W'(10 + r), 4'd6, 2'b11, rand_burst());
            serve_tie("write tie");
            if (ok) begin
                record_write(0);
                record_write(1);
            end
            op_v[0] = host_pkg::op_read;
            op_v[1] = host_pkg::op_read;
            serve_tie("read tie");
            if (ok) begin
                check_read(0, "port 0 burst");
                check_read(1, "port 1 burst");
            end
        end
        finish_test();

        asrt_fail = i_dut.u_asserts.fail_cnt;
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 n_pass, n_fail, asrt_fail);
        if (n_fail == 0 && asrt_fail == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/sdram_pkg.sv
design/host_pkg.sv
design/sdram_req_if.sv
design/req_arbiter.sv
design/sdram_ctrl.sv
design/sdram_model.sv
design/sdram_subsys_top.sv
tests/sdram_subsys_asserts.sv
tests/tb_sdram_subsys.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_subsys \
    -f filelist.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
grep -qx "TB PASSED" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }
